// File: source/cache_pkg.sv
package cache_pkg;

    localparam int word_bits       = 32;
    localparam int words_per_line  = 4;
    localparam int line_bits       = word_bits * words_per_line; // 128
    localparam int num_lines       = 8;
    localparam int index_bits      = 3;
    localparam int offset_bits     = 2;
    localparam int tag_bits        = 25;
    localparam int addr_bits       = tag_bits + index_bits + offset_bits; // word address
    localparam int block_addr_bits = tag_bits + index_bits;

    typedef logic [word_bits-1:0]       word_t;
    typedef logic [line_bits-1:0]       line_t; // word w at bits 32w+31..32w
    typedef logic [tag_bits-1:0]        tag_t;
    typedef logic [index_bits-1:0]      index_t;
    typedef logic [offset_bits-1:0]     offset_t;
    typedef logic [block_addr_bits-1:0] block_addr_t;

    typedef enum logic [1:0]
    {
        idle,
        fill_wait,
        write_wait
    } ctrl_state_t;

    // one word of a block replaced, the rest kept
    function automatic line_t line_put_word
    (
        input line_t   line_in,
        input offset_t offset,
        input word_t   word
    );
        line_t line_out;
        line_out = line_in;
        line_out[offset*word_bits +: word_bits] = word;
        return line_out;
    endfunction

endpackage

// File: source/cache_decode.sv
module cache_decode
    import cache_pkg::*;
(
    input  logic [addr_bits-1:0] proc_addr,
    input  tag_t                 stored_tag,
    input  logic                 stored_valid,
    output index_t               index,
    output tag_t                 tag,
    output offset_t              offset,
    output logic                 hit
);

    // word address fields
    assign offset = proc_addr[offset_bits-1:0];
    assign index  = proc_addr[offset_bits +: index_bits];
    assign tag    = proc_addr[addr_bits-1 -: tag_bits];

    // stale tag of an invalid line never hits
    assign hit = stored_valid && (stored_tag == tag);

endmodule

// File: source/cache_array.sv
module cache_array
    import cache_pkg::*;
(
    input  logic    clk,
    input  logic    proc_reset,
    input  index_t  index,
    input  tag_t    tag,
    input  offset_t offset,
    input  logic    fill_en,
    input  line_t   fill_line,
    input  logic    merge_en,
    input  word_t   merge_word,
    output line_t   stored_line,
    output tag_t    stored_tag,
    output logic    stored_valid
);

    line_t                lines [num_lines];
    tag_t                 tags  [num_lines];
    logic [num_lines-1:0] valid;

    line_t base_line;
    line_t next_line;

    // merge lands on top of the fill for a write miss
    always_comb
    begin
        base_line = fill_en ? fill_line : lines[index];
        next_line = base_line;
        if (merge_en)
        begin
            next_line = line_put_word(base_line, offset, merge_word);
        end
    end

    always_ff @(posedge clk)
    begin
        if (fill_en || merge_en)
        begin
            lines[index] <= next_line;
        end
        if (fill_en)
        begin
            tags[index] <= tag;
        end
    end

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            valid <= '0;
        end
        else if (fill_en)
        begin
            valid[index] <= 1'b1;
        end
    end

    assign stored_line  = lines[index];
    assign stored_tag   = tags[index];
    assign stored_valid = valid[index];

endmodule

// File: source/cache_control.sv
module cache_control
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        proc_reset,
    input  logic        proc_read,
    input  logic        proc_write,
    input  logic        hit,
    input  index_t      index,
    input  tag_t        tag,
    input  offset_t     offset,
    input  word_t       proc_wdata,
    input  line_t       stored_line,
    input  line_t       mem_rdata,
    input  logic        mem_ready,
    output logic        proc_stall,
    output logic        fill_en,
    output logic        merge_en,
    output logic        fill_done,
    output logic        mem_read,
    output logic        mem_write,
    output block_addr_t mem_addr,
    output line_t       mem_wdata
);

    ctrl_state_t state;
    logic        need_mem;
    line_t       merge_base;
    line_t       merged_line;

    // anything but a read hit goes to memory
    assign need_mem = proc_write || (proc_read && !hit);

    always_comb
    begin
        proc_stall = 1'b0;
        fill_en    = 1'b0;
        merge_en   = 1'b0;
        fill_done  = 1'b0;
        case (state)
            idle:
            begin
                proc_stall = need_mem;
                merge_en   = proc_write && hit; // write hit updates line now
            end
            fill_wait:
            begin
                proc_stall = !(mem_ready && proc_read);
                fill_en    = mem_ready;
                merge_en   = mem_ready && proc_write;
                fill_done  = mem_ready && proc_read;
            end
            write_wait:
            begin
                proc_stall = !mem_ready;
            end
            default:
            begin
                proc_stall = 1'b0;
            end
        endcase
    end

    // fresh block on a fill, else the line already held
    assign merge_base  = (state == fill_wait) ? mem_rdata : stored_line;
    assign merged_line = line_put_word(merge_base, offset, proc_wdata);

    always_ff @(posedge clk)
    begin
        if (proc_reset)
        begin
            state     <= idle;
            mem_read  <= 1'b0;
            mem_write <= 1'b0;
            mem_addr  <= '0;
        end
        else
        begin
            case (state)
                idle:
                begin
                    if (need_mem)
                    begin
                        mem_addr <= {tag, index};
                        if (proc_write && hit)
                        begin
                            mem_write <= 1'b1;
                            state     <= write_wait;
                        end
                        else
                        begin
                            mem_read <= 1'b1; // miss, read or write
                            state    <= fill_wait;
                        end
                    end
                end
                fill_wait:
                begin
                    if (mem_ready)
                    begin
                        mem_read <= 1'b0;
                        if (proc_write)
                        begin
                            mem_write <= 1'b1; // same block address
                            state     <= write_wait;
                        end
                        else
                        begin
                            mem_addr <= '0;
                            state    <= idle;
                        end
                    end
                end
                write_wait:
                begin
                    if (mem_ready)
                    begin
                        mem_write <= 1'b0;
                        mem_addr  <= '0;
                        state     <= idle;
                    end
                end
                default:
                begin
                    state <= idle;
                end
            endcase
        end
    end

    // merge_en marks exactly the cycles a block write is issued
    always_ff @(posedge clk)
    begin
        if (merge_en)
        begin
            mem_wdata <= merged_line;
        end
    end

endmodule

// File: source/cache_result.sv
module cache_result
    import cache_pkg::*;
(
    input  offset_t offset,
    input  line_t   stored_line,
    input  line_t   mem_rdata,
    input  logic    fill_done,
    output word_t   proc_rdata
);

    line_t src_line;

    // block arriving this cycle is not in the array yet
    assign src_line = fill_done ? mem_rdata : stored_line;

    assign proc_rdata = src_line[offset*word_bits +: word_bits];

endmodule

// File: source/cache_wt.sv
module cache_wt
    import cache_pkg::*;
(
    input  logic                 clk,
    input  logic                 proc_reset,
    input  logic                 proc_read,
    input  logic                 proc_write,
    input  logic [addr_bits-1:0] proc_addr,
    input  word_t                proc_wdata,
    output logic                 proc_stall,
    output word_t                proc_rdata,
    input  line_t                mem_rdata,
    input  logic                 mem_ready,
    output logic                 mem_read,
    output logic                 mem_write,
    output block_addr_t          mem_addr,
    output line_t                mem_wdata
);

    index_t  index;
    tag_t    tag;
    offset_t offset;
    logic    hit;

    line_t   stored_line;
    tag_t    stored_tag;
    logic    stored_valid;

    logic    fill_en;
    logic    merge_en;
    logic    fill_done;

    cache_decode cache_decode_inst
    (
        .proc_addr    (proc_addr),
        .stored_tag   (stored_tag),
        .stored_valid (stored_valid),
        .index        (index),
        .tag          (tag),
        .offset       (offset),
        .hit          (hit)
    );

    cache_array cache_array_inst
    (
        .clk          (clk),
        .proc_reset   (proc_reset),
        .index        (index),
        .tag          (tag),
        .offset       (offset),
        .fill_en      (fill_en),
        .fill_line    (mem_rdata),
        .merge_en     (merge_en),
        .merge_word   (proc_wdata),
        .stored_line  (stored_line),
        .stored_tag   (stored_tag),
        .stored_valid (stored_valid)
    );

    cache_control cache_control_inst
    (
        .clk         (clk),
        .proc_reset  (proc_reset),
        .proc_read   (proc_read),
        .proc_write  (proc_write),
        .hit         (hit),
        .index       (index),
        .tag         (tag),
        .offset      (offset),
        .proc_wdata  (proc_wdata),
        .stored_line (stored_line),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready),
        .proc_stall  (proc_stall),
        .fill_en     (fill_en),
        .merge_en    (merge_en),
        .fill_done   (fill_done),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata)
    );

    cache_result cache_result_inst
    (
        .offset      (offset),
        .stored_line (stored_line),
        .mem_rdata   (mem_rdata),
        .fill_done   (fill_done),
        .proc_rdata  (proc_rdata)
    );

endmodule

// File: sim/cache_wt_tb.sv
module cache_wt_tb
    import cache_pkg::*;
();

    logic                 clk;
    logic                 proc_reset;
    logic                 proc_read;
    logic                 proc_write;
    logic [addr_bits-1:0] proc_addr;
    word_t                proc_wdata;
    logic                 proc_stall;
    word_t                proc_rdata;
    line_t                mem_rdata;
    logic                 mem_ready;
    logic                 mem_read;
    logic                 mem_write;
    block_addr_t          mem_addr;
    line_t                mem_wdata;

    word_t                mem_store [logic [addr_bits-1:0]]; // words written so far
    logic [31:0]          lcg_state;
    int                   delay_left;
    logic                 mem_busy;
    int                   rd_count;
    int                   wr_count;
    int                   model_errors;

    logic [addr_bits-1:0] cur_addr;
    word_t                cur_wdata;
    int                   error_count;
    int                   test_count;
    int                   fail_count;
    logic                 timed_out;

    cache_wt cache_wt_inst
    (
        .clk        (clk),
        .proc_reset (proc_reset),
        .proc_read  (proc_read),
        .proc_write (proc_write),
        .proc_addr  (proc_addr),
        .proc_wdata (proc_wdata),
        .proc_stall (proc_stall),
        .proc_rdata (proc_rdata),
        .mem_rdata  (mem_rdata),
        .mem_ready  (mem_ready),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // untouched words hold their own address xor a marker
    function automatic word_t model_word(input logic [addr_bits-1:0] addr);
        word_t w;
        if (mem_store.exists(addr))
        begin
            w = mem_store[addr];
        end
        else
        begin
            w = {2'b00, addr} ^ 32'h5a5a0000;
        end
        return w;
    endfunction

    function automatic line_t model_block(input block_addr_t blk);
        line_t l;
        for (int i = 0; i < words_per_line; i++)
        begin
            l[i*word_bits +: word_bits] = model_word({blk, offset_t'(i)});
        end
        return l;
    endfunction

    task automatic serve_request();
        line_t       expect_line;
        block_addr_t exp_block;
        int          i;
        exp_block = cur_addr[addr_bits-1:offset_bits];
        if (mem_addr !== exp_block)
        begin
            $display("Error: mem_addr = %h, expected %h", mem_addr, exp_block);
            model_errors++;
        end
        if (mem_read)
        begin
            rd_count++;
            mem_rdata <= model_block(mem_addr);
        end
        else
        begin
            wr_count++;
            for (i = 0; i < words_per_line; i++)
            begin
                if (offset_t'(i) == cur_addr[offset_bits-1:0])
                begin
                    expect_line[i*word_bits +: word_bits] = cur_wdata;
                end
                else
                begin
                    expect_line[i*word_bits +: word_bits] = model_word({exp_block, offset_t'(i)});
                end
            end
            if (mem_wdata !== expect_line)
            begin
                $display("Error: mem_wdata = %h, expected %h", mem_wdata, expect_line);
                model_errors++;
            end
            for (i = 0; i < words_per_line; i++)
            begin
                mem_store[{mem_addr, offset_t'(i)}] = expect_line[i*word_bits +: word_bits];
            end
        end
    endtask

    // memory with 1 to 4 cycles of latency per transfer
    initial
    begin
        mem_ready    <= 1'b0;
        mem_rdata    <= '0;
        lcg_state    = 32'haded;
        mem_busy     = 1'b0;
        delay_left   = 0;
        rd_count     = 0;
        wr_count     = 0;
        model_errors = 0;
        forever
        begin
            @(posedge clk);
            if (proc_reset)
            begin
                mem_ready <= 1'b0;
                mem_busy  = 1'b0;
            end
            else if (mem_ready)
            begin
                mem_ready <= 1'b0; // one-cycle pulse
            end
            else if (mem_read || mem_write)
            begin
                if (!mem_busy)
                begin
                    mem_busy   = 1'b1;
                    lcg_state  = lcg_next(lcg_state);
                    delay_left = 1 + int'(lcg_state[17:16]);
                end
                delay_left = delay_left - 1;
                if (delay_left == 0)
                begin
                    mem_busy = 1'b0;
                    mem_ready <= 1'b1;
                    serve_request();
                end
            end
        end
    end

    task automatic check_reset_state();
        int errors_before;
        errors_before = error_count;
        if (proc_stall !== 1'b0)
        begin
            $display("Error: proc_stall = %h, expected 0", proc_stall);
            error_count++;
        end
        if (mem_read !== 1'b0 || mem_write !== 1'b0)
        begin
            $display("Error: mem_read/mem_write = %h/%h, expected 0/0", mem_read, mem_write);
            error_count++;
        end
        if (mem_addr !== '0)
        begin
            $display("Error: mem_addr = %h, expected 0", mem_addr);
            error_count++;
        end
        test_count++;
        if (error_count == errors_before)
        begin
            $display("reset state: ok");
        end
        else
        begin
            $display("reset state: failed");
            fail_count++;
        end
    endtask

    task automatic run_access(input int num, input logic is_write,
                              input logic [addr_bits-1:0] addr, input word_t wdata,
                              input word_t exp_rdata, input int exp_reads, input int exp_writes);
        int errors_before;
        int rd_start;
        int wr_start;
        int cycles;
        errors_before = error_count + model_errors;
        rd_start      = rd_count;
        wr_start      = wr_count;
        cur_addr      = addr;
        cur_wdata     = wdata;
        @(posedge clk);
        proc_read  <= !is_write;
        proc_write <= is_write;
        proc_addr  <= addr;
        proc_wdata <= wdata;
        @(negedge clk);
        cycles = 0;
        while (proc_stall && cycles < 50)
        begin
            @(negedge clk);
            cycles++;
        end
        if (proc_stall)
        begin
            $display("Timeout: access %0d still stalled after 50 cycles", num);
            error_count++;
            timed_out = 1'b1;
        end
        else
        begin
            if (exp_reads + exp_writes == 0 && cycles != 0)
            begin
                $display("access %0d should hit but stalled for %0d cycles", num, cycles);
                error_count++;
            end
            if (exp_reads + exp_writes != 0 && mem_ready !== 1'b1)
            begin
                $display("access %0d completed before memory answered", num);
                error_count++;
            end
            if (rd_count - rd_start != exp_reads)
            begin
                $display("Error: mem_read requests = %h, expected %h", rd_count - rd_start,
                         exp_reads);
                error_count++;
            end
            if (wr_count - wr_start != exp_writes)
            begin
                $display("Error: mem_write requests = %h, expected %h", wr_count - wr_start,
                         exp_writes);
                error_count++;
            end
            if (!is_write && proc_rdata !== exp_rdata)
            begin
                $display("Error: proc_rdata = %h, expected %h", proc_rdata, exp_rdata);
                error_count++;
            end
        end
        @(posedge clk);
        proc_read  <= 1'b0;
        proc_write <= 1'b0;
        @(negedge clk);
        test_count++;
        if (error_count + model_errors == errors_before)
        begin
            $display("access %0d (%s %h): ok", num, is_write ? "write" : "read ", addr);
        end
        else
        begin
            $display("access %0d (%s %h): failed", num, is_write ? "write" : "read ", addr);
            fail_count++;
        end
    endtask

    task automatic run_golden();
        int          fd;
        int          n;
        int          num;
        string       line;
        logic [39:0] op_name;
        word_t       addr_word;
        word_t       wdata;
        word_t       exp_rdata;
        int          exp_reads;
        int          exp_writes;
        num = 0;
        fd  = $fopen("sim/cache_wt_golden.txt", "r");
        if (fd == 0)
        begin
            $display("could not open sim/cache_wt_golden.txt");
            error_count++;
        end
        else
        begin
            while (!timed_out && $fgets(line, fd) != 0)
            begin
                if (line.len() > 1 && line[0] != "#")
                begin
                    n = $sscanf(line, "%s %h %h %h %d %d", op_name, addr_word, wdata,
                                exp_rdata, exp_reads, exp_writes);
                    if (n != 6 || (line[0] != "r" && line[0] != "w"))
                    begin
                        $display("golden line could not be parsed: %s", line);
                        error_count++;
                    end
                    else
                    begin
                        num++;
                        run_access(num, line[0] == "w", addr_word[addr_bits-1:0], wdata,
                                   exp_rdata, exp_reads, exp_writes);
                    end
                end
            end
            $fclose(fd);
            if (num == 0)
            begin
                $display("golden file held no accesses");
                error_count++;
            end
        end
    endtask

    initial
    begin
        proc_reset  <= 1'b1;
        proc_read   <= 1'b0;
        proc_write  <= 1'b0;
        proc_addr   <= '0;
        proc_wdata  <= '0;
        cur_addr    = '0;
        cur_wdata   = '0;
        error_count = 0;
        test_count  = 0;
        fail_count  = 0;
        timed_out   = 1'b0;
        repeat (3) @(posedge clk);
        proc_reset <= 1'b0;
        @(negedge clk);
        check_reset_state();
        run_golden();
        $display("%0d tests, %0d failed, %0d errors", test_count, fail_count,
                 error_count + model_errors);
        if (error_count + model_errors == 0 && !timed_out)
        begin
            $display("Simulation finished: PASS");
        end
        else
        begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: sim/cache_wt_golden.txt
# op addr wdata rdata mem_reads mem_writes
# addresses and data in hex, request counts in decimal
read  00000010 00000000 5a5a0010 1 0
read  00000013 00000000 5a5a0013 0 0
read  00000011 00000000 5a5a0011 0 0
write 00000012 cafe0012 00000000 0 1
read  00000012 00000000 cafe0012 0 0
read  00000010 00000000 5a5a0010 0 0
write 00000025 12340025 00000000 1 1
read  00000025 00000000 12340025 0 0
read  00000024 00000000 5a5a0024 0 0
read  00000027 00000000 5a5a0027 0 0
read  00000031 00000000 5a5a0031 1 0
read  00000012 00000000 cafe0012 1 0
read  00000032 00000000 5a5a0032 1 0
read  00000010 00000000 5a5a0010 1 0
write 00000033 beef0033 00000000 1 1
read  00000033 00000000 beef0033 0 0
read  00000013 00000000 5a5a0013 1 0
read  00000033 00000000 beef0033 1 0
read  3ffffffe 00000000 65a5fffe 1 0
write 3fffffff 0f0f0f0f 00000000 0 1
read  3fffffff 00000000 0f0f0f0f 0 0
read  3ffffffc 00000000 65a5fffc 0 0
read  0000001d 00000000 5a5a001d 1 0
read  3fffffff 00000000 0f0f0f0f 1 0
write 12345681 a5a5a5a5 00000000 1 1
read  12345681 00000000 a5a5a5a5 0 0
read  12345682 00000000 486e5682 0 0
read  00000012 00000000 cafe0012 1 0
read  00000025 00000000 12340025 0 0

// File: cache_wt.f
source/cache_pkg.sv
source/cache_decode.sv
source/cache_array.sv
source/cache_control.sv
source/cache_result.sv
source/cache_wt.sv
sim/cache_wt_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module cache_wt_tb -f cache_wt.f -o cache_wt_sim

out=$(./obj_dir/cache_wt_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation finished: PASS"
then
    exit 0
fi
exit 1
